/* sources.f */
src/dac_pkg.sv
src/dac_ctrl_regs.sv
src/awg_player.sv
src/dac_output_stage.sv
src/dac_bist_top.sv
testbench/tb_dac_bist.sv

/* Makefile */
TOP = tb_dac_bist

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

/* testbench/tb_dac_bist.sv */
`default_nettype none

module tb_dac_bist;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int AWG_DEPTH = 256;
    // Loop length used for the AWG sequence checks
    localparam int AWG_LEN = 12;
    localparam logic [11:0] A_CTRL = 12'(dac_pkg::REG_CTRL);
    localparam logic [11:0] A_LEN = 12'(dac_pkg::REG_AWG_LEN);
    localparam logic [11:0] A_WIN = dac_pkg::AWG_WIN_BASE;
    // First byte past the window
    localparam logic [11:0] A_WIN_END = 12'h400 + 12'(4 * AWG_DEPTH);
    // I word with only the DCI bit set
    localparam dac_pkg::dac_word_t IDLE_D2 = 15'h4000;

    logic                       dac_clk_out;
    logic                       rst_n_i;
    logic [dac_pkg::APB_AW-1:0] paddr_i;
    logic                       psel_i;
    logic                       penable_i;
    logic                       pwrite_i;
    logic [31:0]                pwdata_i;
    logic [31:0]                prdata_o;
    logic                       pready_o;
    logic                       pslverr_o;
    dac_pkg::dac_sample_t       dac_in_data_i_i;
    dac_pkg::dac_sample_t       dac_in_data_q_i_i;
    dac_pkg::dac_word_t         dac_d1_o;
    dac_pkg::dac_word_t         dac_d2_o;

    integer                     seed;
    int                         errors = 0;
    // Mirror of the CTRL register as the DUT holds it
    logic [4:0]                 ctrl_shadow;
    dac_pkg::dac_sample_t       awg_seq [AWG_LEN];
    dac_pkg::dac_word_t         exp_d2;
    dac_pkg::dac_word_t         exp_d1;
    logic                       exp_chk_i;
    logic                       exp_chk_q;

    dac_bist_top #(
        .AWG_DEPTH         (AWG_DEPTH)
    ) dut0 (
        .dac_clk_out       (dac_clk_out),
        .rst_n_i           (rst_n_i),
        .paddr_i           (paddr_i),
        .psel_i            (psel_i),
        .penable_i         (penable_i),
        .pwrite_i          (pwrite_i),
        .pwdata_i          (pwdata_i),
        .prdata_o          (prdata_o),
        .pready_o          (pready_o),
        .pslverr_o         (pslverr_o),
        .dac_in_data_i_i   (dac_in_data_i_i),
        .dac_in_data_q_i_i (dac_in_data_q_i_i),
        .dac_d1_o          (dac_d1_o),
        .dac_d2_o          (dac_d2_o)
    );

    // 40 ns period
    always #20 dac_clk_out = ~dac_clk_out;

    // Fresh random I/Q every cycle
    always @(posedge dac_clk_out) begin
        dac_in_data_i_i   <= dac_pkg::dac_sample_t'($random(seed));
        dac_in_data_q_i_i <= dac_pkg::dac_sample_t'($random(seed));
    end

    // ----------------------------------------
    // Reporting
    // ----------------------------------------

    task automatic end_run();
        $display("Run finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
        end_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Expected frame words
    // ----------------------------------------

    // Returns the I word above the Q word
    function automatic logic [2*dac_pkg::DAC_DW+1:0] ref_frame(
        input logic en_i, input logic sel_i, input logic en_q, input logic sel_q,
        input dac_pkg::dac_sample_t ext_i, input dac_pkg::dac_sample_t ext_q,
        input dac_pkg::dac_sample_t awg);
        dac_pkg::dac_sample_t s_i;
        dac_pkg::dac_sample_t s_q;
        s_i = '0;
        s_q = '0;
        if (en_i) begin
            s_i = sel_i ? awg : ext_i;
        end
        if (en_q) begin
            s_q = sel_q ? awg : ext_q;
        end
        return {1'b1, s_i, 1'b0, s_q};
    endfunction

    // Inputs seen here are sampled on the next rising edge,
    // so the words computed now are checked one negedge later
    always @(negedge dac_clk_out) begin
        if (exp_chk_i) begin
            check_value("dac_d2_o", 32'(dac_d2_o), 32'(exp_d2));
        end
        if (exp_chk_q) begin
            check_value("dac_d1_o", 32'(dac_d1_o), 32'(exp_d1));
        end
        {exp_d2, exp_d1} = ref_frame(ctrl_shadow[dac_pkg::CTRL_DAC0_EN],
                                     ctrl_shadow[dac_pkg::CTRL_DAC0_SRCSEL],
                                     ctrl_shadow[dac_pkg::CTRL_DAC1_EN],
                                     ctrl_shadow[dac_pkg::CTRL_DAC1_SRCSEL],
                                     dac_in_data_i_i, dac_in_data_q_i_i, '0);
        // AWG-fed channels are left to the sequence checks
        exp_chk_i = rst_n_i && !(ctrl_shadow[dac_pkg::CTRL_DAC0_EN] &&
                                 ctrl_shadow[dac_pkg::CTRL_DAC0_SRCSEL]);
        exp_chk_q = rst_n_i && !(ctrl_shadow[dac_pkg::CTRL_DAC1_EN] &&
                                 ctrl_shadow[dac_pkg::CTRL_DAC1_SRCSEL]);
    end

    // ----------------------------------------
    // APB manager
    // ----------------------------------------

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        int waits;
        @(posedge dac_clk_out);
        paddr_i   <= addr;
        pwdata_i  <= data;
        pwrite_i  <= 1'b1;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge dac_clk_out);
        penable_i <= 1'b1;
        waits = 0;
        @(negedge dac_clk_out);
        while (!pready_o && waits < 16) begin
            @(negedge dac_clk_out);
            waits++;
        end
        if (!pready_o) begin
            report_timeout("pready_o on an APB write");
        end else begin
            check_value("pslverr_o", 32'(pslverr_o), 32'(exp_err));
        end
        // The register takes the value on the access edge
        @(posedge dac_clk_out);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        if (addr == A_CTRL) begin
            ctrl_shadow = data[4:0];
        end
    endtask

    task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        int waits;
        @(posedge dac_clk_out);
        paddr_i   <= addr;
        pwrite_i  <= 1'b0;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge dac_clk_out);
        penable_i <= 1'b1;
        waits = 0;
        @(negedge dac_clk_out);
        while (!pready_o && waits < 16) begin
            @(negedge dac_clk_out);
            waits++;
        end
        if (!pready_o) begin
            report_timeout("pready_o on an APB read");
        end else begin
            check_value("prdata_o", prdata_o, exp_data);
            check_value("pslverr_o", 32'(pslverr_o), 32'(exp_err));
        end
        @(posedge dac_clk_out);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    // ----------------------------------------
    // AWG sequence checks
    // ----------------------------------------

    // Finds the first nonzero I word and its place in the sequence
    task automatic wait_awg_start(output int idx);
        int   waits;
        logic found;
        waits = 0;
        found = 1'b0;
        idx   = 0;
        @(negedge dac_clk_out);
        while (dac_d2_o[dac_pkg::DAC_DW-1:0] == '0 && waits < 32) begin
            @(negedge dac_clk_out);
            waits++;
        end
        if (dac_d2_o[dac_pkg::DAC_DW-1:0] == '0) begin
            report_timeout("the first AWG sample");
        end else begin
            for (int k = 0; k < AWG_LEN; k++) begin
                if (dac_d2_o[dac_pkg::DAC_DW-1:0] == awg_seq[k]) begin
                    idx   = k;
                    found = 1'b1;
                end
            end
            if (!found) begin
                $display("First AWG word 0x%h is not one of the written samples", dac_d2_o);
                errors++;
            end
        end
    endtask

    // Checks from the current negedge on
    task automatic follow_awg(input int start, input int cycles, input logic with_q);
        int                 idx;
        dac_pkg::dac_word_t want_d2;
        dac_pkg::dac_word_t want_d1;
        idx = start;
        for (int n = 0; n < cycles; n++) begin
            if (n > 0) begin
                @(negedge dac_clk_out);
            end
            // Both channels enabled on the AWG source
            {want_d2, want_d1} = ref_frame(1'b1, 1'b1, 1'b1, 1'b1, '0, '0, awg_seq[idx]);
            check_value("dac_d2_o", 32'(dac_d2_o), 32'(want_d2));
            if (with_q) begin
                check_value("dac_d1_o", 32'(dac_d1_o), 32'(want_d1));
            end
            idx = (idx + 1) % AWG_LEN;
        end
    endtask

    task automatic wait_awg_idle();
        int waits;
        waits = 0;
        @(negedge dac_clk_out);
        while ((dac_d2_o != IDLE_D2 || dac_d1_o != '0) && waits < 16) begin
            @(negedge dac_clk_out);
            waits++;
        end
        if (dac_d2_o != IDLE_D2 || dac_d1_o != '0) begin
            report_timeout("both AWG channels to go idle");
        end else begin
            // Must stay at zero
            repeat (8) begin
                @(negedge dac_clk_out);
                check_value("dac_d2_o", 32'(dac_d2_o), 32'(IDLE_D2));
                check_value("dac_d1_o", 32'(dac_d1_o), 32'h0);
            end
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        int start_idx;
        dac_clk_out       = 1'b0;
        rst_n_i           = 1'b0;
        paddr_i           = '0;
        psel_i            = 1'b0;
        penable_i         = 1'b0;
        pwrite_i          = 1'b0;
        pwdata_i          = '0;
        dac_in_data_i_i   = '0;
        dac_in_data_q_i_i = '0;
        seed              = 32'h7531_fa4f;
        ctrl_shadow       = '0;
        exp_chk_i         = 1'b0;
        exp_chk_q         = 1'b0;
        // Distinct and nonzero with some negative values
        for (int k = 0; k < AWG_LEN; k++) begin
            awg_seq[k] = dac_pkg::dac_sample_t'(k * 1301 + 97);
        end
        repeat (8) @(posedge dac_clk_out);
        rst_n_i <= 1'b1;

        // Reset state
        @(negedge dac_clk_out);
        check_value("dac_d2_o", 32'(dac_d2_o), 32'(IDLE_D2));
        check_value("dac_d1_o", 32'(dac_d1_o), 32'h0);
        apb_read(A_CTRL, 32'h0, 1'b0);
        apb_read(A_LEN, 32'(AWG_DEPTH), 1'b0);

        // Register access, length clamping and decode errors
        apb_write(A_CTRL, 32'h0A, 1'b0);
        apb_read(A_CTRL, 32'h0A, 1'b0);
        apb_write(A_CTRL, 32'h35, 1'b0);
        apb_read(A_CTRL, 32'h15, 1'b0);
        apb_write(A_LEN, 32'd100, 1'b0);
        apb_read(A_LEN, 32'd100, 1'b0);
        apb_write(A_LEN, 32'd0, 1'b0);
        apb_read(A_LEN, 32'd1, 1'b0);
        apb_write(A_LEN, 32'd1000, 1'b0);
        apb_read(A_LEN, 32'(AWG_DEPTH), 1'b0);
        apb_read(12'h010, 32'h0, 1'b1);
        apb_write(12'h010, 32'h1, 1'b1);
        apb_read(12'h008, 32'h0, 1'b1);
        apb_read(A_WIN_END, 32'h0, 1'b1);
        apb_write(A_WIN_END - 12'd4, 32'h5, 1'b0);
        apb_read(A_WIN, 32'h0, 1'b0);
        apb_read(A_CTRL, 32'h15, 1'b0);

        // External path through the comparing process
        apb_write(A_CTRL, 32'h0A, 1'b0);
        repeat (32) @(posedge dac_clk_out);
        apb_write(A_CTRL, 32'h08, 1'b0);
        repeat (16) @(posedge dac_clk_out);
        apb_write(A_CTRL, 32'h02, 1'b0);
        repeat (16) @(posedge dac_clk_out);
        apb_write(A_CTRL, 32'h00, 1'b0);

        // AWG loop on both channels
        apb_write(A_LEN, 32'(AWG_LEN), 1'b0);
        for (int k = 0; k < AWG_LEN; k++) begin
            apb_write(A_WIN + 12'(4 * k), 32'(awg_seq[k]), 1'b0);
        end
        apb_write(A_CTRL, 32'h1F, 1'b0);
        wait_awg_start(start_idx);
        follow_awg(start_idx, 40, 1'b1);

        // Disable, then restart from sample 0
        apb_write(A_CTRL, 32'h0F, 1'b0);
        wait_awg_idle();
        apb_write(A_CTRL, 32'h1F, 1'b0);
        wait_awg_start(start_idx);
        check_value("AWG restart index", 32'(start_idx), 32'h0);
        follow_awg(start_idx, 24, 1'b1);

        // I from AWG, Q from the external input
        apb_write(A_CTRL, 32'h1B, 1'b0);
        wait_awg_start(start_idx);
        follow_awg(start_idx, 36, 1'b0);

        apb_write(A_CTRL, 32'h00, 1'b0);
        repeat (4) @(posedge dac_clk_out);
        end_run();
    end

endmodule

`default_nettype wire

/* src/dac_bist_top.sv */
`default_nettype none

module dac_bist_top #(
    parameter int AWG_DEPTH = 256,
    localparam int AW = $clog2(AWG_DEPTH),
    localparam int LW = AW + 1
) (
    input  logic                         dac_clk_out,
    input  logic                         rst_n_i,
    // APB3 slave
    input  logic [dac_pkg::APB_AW-1:0]   paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [31:0]                  pwdata_i,
    output logic [31:0]                  prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    // External I/Q, already in the DAC clock domain
    input  dac_pkg::dac_sample_t         dac_in_data_i_i,
    input  dac_pkg::dac_sample_t         dac_in_data_q_i_i,
    // Q and I frame words
    output dac_pkg::dac_word_t           dac_d1_o,
    output dac_pkg::dac_word_t           dac_d2_o
);

    // Control bits
    logic                 dac0_en;
    logic                 dac0_src_sel;
    logic                 dac1_en;
    logic                 dac1_src_sel;
    logic                 awg_en;
    // AWG configuration and write port
    logic [LW-1:0]        awg_len;
    logic                 awg_wr_en;
    logic [AW-1:0]        awg_wr_addr;
    dac_pkg::dac_sample_t awg_wr_data;
    // AWG stream
    dac_pkg::dac_sample_t awg_sample;
    logic                 awg_valid;

    // ----------------------------------------
    // Register block
    // ----------------------------------------

    dac_ctrl_regs #(
        .AWG_DEPTH      (AWG_DEPTH)
    ) u_regs (
        .dac_clk_out    (dac_clk_out),
        .rst_n_i        (rst_n_i),
        .paddr_i        (paddr_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .dac0_en_o      (dac0_en),
        .dac0_src_sel_o (dac0_src_sel),
        .dac1_en_o      (dac1_en),
        .dac1_src_sel_o (dac1_src_sel),
        .awg_en_o       (awg_en),
        .awg_len_o      (awg_len),
        .awg_wr_en_o    (awg_wr_en),
        .awg_wr_addr_o  (awg_wr_addr),
        .awg_wr_data_o  (awg_wr_data)
    );

    // ----------------------------------------
    // Self-test waveform source
    // ----------------------------------------

    awg_player #(
        .AWG_DEPTH      (AWG_DEPTH)
    ) u_awg (
        .dac_clk_out    (dac_clk_out),
        .rst_n_i        (rst_n_i),
        .awg_en_i       (awg_en),
        .awg_len_i      (awg_len),
        .awg_wr_en_i    (awg_wr_en),
        .awg_wr_addr_i  (awg_wr_addr),
        .awg_wr_data_i  (awg_wr_data),
        .awg_sample_o   (awg_sample),
        .awg_valid_o    (awg_valid)
    );

    // Mux and DDR packing
    dac_output_stage u_out (
        .dac_clk_out       (dac_clk_out),
        .rst_n_i           (rst_n_i),
        .dac_in_data_i_i   (dac_in_data_i_i),
        .dac_in_data_q_i_i (dac_in_data_q_i_i),
        .awg_sample_i      (awg_sample),
        .awg_valid_i       (awg_valid),
        .dac0_en_i         (dac0_en),
        .dac0_src_sel_i    (dac0_src_sel),
        .dac1_en_i         (dac1_en),
        .dac1_src_sel_i    (dac1_src_sel),
        .dac_d1_o          (dac_d1_o),
        .dac_d2_o          (dac_d2_o)
    );

endmodule

`default_nettype wire

/* src/dac_output_stage.sv */
`default_nettype none

module dac_output_stage (
    input  logic                 dac_clk_out,
    input  logic                 rst_n_i,
    // Sample sources
    input  dac_pkg::dac_sample_t dac_in_data_i_i,
    input  dac_pkg::dac_sample_t dac_in_data_q_i_i,
    input  dac_pkg::dac_sample_t awg_sample_i,
    input  logic                 awg_valid_i,
    // Channel control
    input  logic                 dac0_en_i,
    input  logic                 dac0_src_sel_i,
    input  logic                 dac1_en_i,
    input  logic                 dac1_src_sel_i,
    // DDR frame words
    output dac_pkg::dac_word_t   dac_d1_o,
    output dac_pkg::dac_word_t   dac_d2_o
);

    dac_pkg::dac_sample_t awg_gated;
    dac_pkg::dac_sample_t i_mux;
    dac_pkg::dac_sample_t q_mux;

    // ----------------------------------------
    // Source select
    // ----------------------------------------

    // Idle AWG contributes zero
    assign awg_gated = awg_valid_i ? awg_sample_i : '0;

    // I channel, DAC0
    assign i_mux = dac0_en_i ? (dac0_src_sel_i ? awg_gated : dac_in_data_i_i) : '0;
    // Q channel, DAC1
    assign q_mux = dac1_en_i ? (dac1_src_sel_i ? awg_gated : dac_in_data_q_i_i) : '0;

    // ----------------------------------------
    // Frame packing
    // ----------------------------------------

    // D2 goes out on the rising half with DCI high, D1 with DCI low
    always_ff @(posedge dac_clk_out or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dac_d2_o <= {1'b1, {dac_pkg::DAC_DW{1'b0}}};
            dac_d1_o <= '0;
        end else begin
            dac_d2_o <= {1'b1, i_mux};
            dac_d1_o <= {1'b0, q_mux};
        end
    end

endmodule

`default_nettype wire

/* src/awg_player.sv */
`default_nettype none

module awg_player #(
    parameter int AWG_DEPTH = 256,
    localparam int AW = $clog2(AWG_DEPTH),
    localparam int LW = AW + 1
) (
    input  logic                 dac_clk_out,
    input  logic                 rst_n_i,
    // Playback control
    input  logic                 awg_en_i,
    input  logic [LW-1:0]        awg_len_i,
    // Sample memory write port
    input  logic                 awg_wr_en_i,
    input  logic [AW-1:0]        awg_wr_addr_i,
    input  dac_pkg::dac_sample_t awg_wr_data_i,
    // Sample stream
    output dac_pkg::dac_sample_t awg_sample_o,
    output logic                 awg_valid_o
);

    // Waveform storage
    dac_pkg::dac_sample_t mem [AWG_DEPTH];

    logic [AW-1:0] ptr_q;
    logic [LW-1:0] last_idx;
    logic          wrap;

    // ----------------------------------------
    // Sample memory
    // ----------------------------------------

    // Write side from the APB window
    always_ff @(posedge dac_clk_out) begin
        if (awg_wr_en_i) begin
            mem[awg_wr_addr_i] <= awg_wr_data_i;
        end
    end

    // ----------------------------------------
    // Playback pointer
    // ----------------------------------------

    // Index of the last sample in the loop
    assign last_idx = awg_len_i - LW'(1);
    // Also wraps if the length shrinks mid-loop
    assign wrap     = ({1'b0, ptr_q} >= last_idx);

    always_ff @(posedge dac_clk_out or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q       <= '0;
            awg_valid_o <= 1'b0;
        end else if (!awg_en_i) begin
            // Parked at 0 so a new enable starts at sample 0
            ptr_q       <= '0;
            awg_valid_o <= 1'b0;
        end else begin
            ptr_q       <= wrap ? '0 : ptr_q + AW'(1);
            awg_valid_o <= 1'b1;
        end
    end

    // Read side, aligned with awg_valid_o
    always_ff @(posedge dac_clk_out) begin
        awg_sample_o <= mem[ptr_q];
    end

endmodule

`default_nettype wire

/* src/dac_ctrl_regs.sv */
`default_nettype none

module dac_ctrl_regs #(
    parameter int AWG_DEPTH = 256,
    localparam int AW = $clog2(AWG_DEPTH),
    localparam int LW = AW + 1
) (
    input  logic                         dac_clk_out,
    input  logic                         rst_n_i,
    // APB3 slave
    input  logic [dac_pkg::APB_AW-1:0]   paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [31:0]                  pwdata_i,
    output logic [31:0]                  prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    // Channel and AWG control
    output logic                         dac0_en_o,
    output logic                         dac0_src_sel_o,
    output logic                         dac1_en_o,
    output logic                         dac1_src_sel_o,
    output logic                         awg_en_o,
    // AWG length and memory write port
    output logic [LW-1:0]                awg_len_o,
    output logic                         awg_wr_en_o,
    output logic [AW-1:0]                awg_wr_addr_o,
    output dac_pkg::dac_sample_t         awg_wr_data_o
);

    // Width of the stored control field
    localparam int CW = dac_pkg::CTRL_AWG_EN + 1;
    // First byte address past the sample window
    localparam int WIN_END = int'(dac_pkg::AWG_WIN_BASE) + 4 * AWG_DEPTH;

    logic                        acc;
    logic                        wr_acc;
    logic                        rd_acc;
    logic                        upper_zero;
    logic                        hit_ctrl;
    logic                        hit_len;
    logic                        hit_win;
    logic [dac_pkg::APB_AW-1:0]  win_off;
    logic [LW-1:0]               len_next;
    logic [CW-1:0]               ctrl_q;
    logic [LW-1:0]               len_q;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------

    // Access phase of an APB transfer
    assign acc    = psel_i & penable_i;
    assign wr_acc = acc & pwrite_i;
    assign rd_acc = acc & ~pwrite_i;

    // Plain registers live in the low 256 bytes
    assign upper_zero = (paddr_i[dac_pkg::APB_AW-1:8] == '0);
    assign hit_ctrl   = upper_zero &&
                        (dac_pkg::dac_reg_e'(paddr_i[7:0]) == dac_pkg::REG_CTRL);
    assign hit_len    = upper_zero &&
                        (dac_pkg::dac_reg_e'(paddr_i[7:0]) == dac_pkg::REG_AWG_LEN);
    assign hit_win    = (paddr_i >= dac_pkg::AWG_WIN_BASE) && (int'(paddr_i) < WIN_END);

    // Byte offset inside the window, one sample per word
    assign win_off = paddr_i - dac_pkg::AWG_WIN_BASE;

    // Clamp length into 1..AWG_DEPTH
    always_comb begin
        if (pwdata_i == '0) begin
            len_next = LW'(1);
        end else if (pwdata_i > 32'(AWG_DEPTH)) begin
            len_next = LW'(AWG_DEPTH);
        end else begin
            len_next = pwdata_i[LW-1:0];
        end
    end

    // ----------------------------------------
    // Register storage
    // ----------------------------------------

    always_ff @(posedge dac_clk_out or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q      <= '0;
            len_q       <= LW'(AWG_DEPTH);
            awg_wr_en_o <= 1'b0;
        end else begin
            if (wr_acc && hit_ctrl) begin
                ctrl_q <= pwdata_i[CW-1:0];
            end
            if (wr_acc && hit_len) begin
                len_q <= len_next;
            end
            // Single cycle strobe per window write
            awg_wr_en_o <= wr_acc & hit_win;
        end
    end

    // Write payload, qualified by the strobe
    always_ff @(posedge dac_clk_out) begin
        awg_wr_addr_o <= win_off[AW+1:2];
        awg_wr_data_o <= pwdata_i[dac_pkg::DAC_DW-1:0];
    end

    // ----------------------------------------
    // Read data and response
    // ----------------------------------------

    // Window is write-only, reads give zero
    always_comb begin
        prdata_o = '0;
        if (rd_acc) begin
            if (hit_ctrl) begin
                prdata_o = 32'(ctrl_q);
            end else if (hit_len) begin
                prdata_o = 32'(len_q);
            end
        end
    end

    // No wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = acc & ~(hit_ctrl | hit_len | hit_win);

    // Control bit fan-out
    assign dac0_src_sel_o = ctrl_q[dac_pkg::CTRL_DAC0_SRCSEL];
    assign dac0_en_o      = ctrl_q[dac_pkg::CTRL_DAC0_EN];
    assign dac1_src_sel_o = ctrl_q[dac_pkg::CTRL_DAC1_SRCSEL];
    assign dac1_en_o      = ctrl_q[dac_pkg::CTRL_DAC1_EN];
    assign awg_en_o       = ctrl_q[dac_pkg::CTRL_AWG_EN];
    assign awg_len_o      = len_q;

endmodule

`default_nettype wire

/* src/dac_pkg.sv */
`default_nettype none

package dac_pkg;

    // ----------------------------------------
    // Sample and frame word formats
    // ----------------------------------------

    // DAC converter resolution
    localparam int DAC_DW = 14;

    // Two's complement sample as seen by the converter
    typedef logic signed [DAC_DW-1:0] dac_sample_t;

    // DDR frame word, DCI level in the MSB
    typedef logic [DAC_DW:0] dac_word_t;

    // ----------------------------------------
    // APB register map
    // ----------------------------------------

    // Byte address width of the register space
    localparam int APB_AW = 12;

    // Word offsets of the plain registers
    typedef enum logic [7:0] {
        REG_CTRL    = 8'h00,
        REG_AWG_LEN = 8'h04
    } dac_reg_e;

    // Start of the write-only AWG sample window
    localparam logic [11:0] AWG_WIN_BASE = 12'h400;

    // Bit positions inside REG_CTRL
    localparam int CTRL_DAC0_SRCSEL = 0;
    localparam int CTRL_DAC0_EN     = 1;
    localparam int CTRL_DAC1_SRCSEL = 2;
    localparam int CTRL_DAC1_EN     = 3;
    localparam int CTRL_AWG_EN      = 4;

endpackage

`default_nettype wire
